//--- rs_div_pkg.sv
package rs_div_pkg;

    localparam int rs_entries = 16;
    localparam int idx_w      = $clog2(rs_entries);
    localparam int tag_w      = 8;
    localparam int data_w     = 32;
    localparam int pc_w       = 32;
    localparam int aluop_w    = 4;

    // lowest bus index wins on a tag clash
    localparam int num_buses = 4;
    localparam int bus_alu   = 0;
    localparam int bus_mul   = 1;
    localparam int bus_div   = 2;
    localparam int bus_mem   = 3; // load data

    localparam int bus_prio [num_buses] = '{bus_alu, bus_mul, bus_div, bus_mem};

    typedef logic [idx_w-1:0]      entry_idx_t;
    typedef logic [rs_entries-1:0] entry_mask_t;
    typedef logic [tag_w-1:0]      tag_t;   // physical register
    typedef logic [data_w-1:0]     data_t;
    typedef logic [pc_w-1:0]       pc_t;
    typedef logic [aluop_w-1:0]    aluop_t;

    typedef struct packed {
        logic  valid;
        tag_t  tag;
        data_t data;
    } result_bus_t;

    typedef result_bus_t [num_buses-1:0] result_buses_t;

    typedef struct packed {
        tag_t  tag;
        data_t data;
        logic  valid; // operand already available
    } dispatch_src_t;

    typedef struct packed {
        logic          valid;
        pc_t           pc;
        tag_t          rd;
        aluop_t        aluop;
        dispatch_src_t src1;
        dispatch_src_t src2;
    } dispatch_t;

    typedef struct packed {
        pc_t    pc;
        tag_t   rd;
        aluop_t aluop;
    } payload_t;

    typedef payload_t [rs_entries-1:0] payload_array_t;
    typedef data_t [rs_entries-1:0]    data_array_t;

    // word handed to the divider
    typedef struct packed {
        logic   valid;
        pc_t    pc;
        tag_t   rd;
        aluop_t aluop;
        data_t  data1;
        data_t  data2;
    } issue_t;

endpackage

//--- entry_alloc.sv
`timescale 1ns/1ps

module entry_alloc (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       dispatch_valid,
    input  rs_div_pkg::pc_t            pc,
    input  rs_div_pkg::tag_t           rd,
    input  rs_div_pkg::aluop_t         aluop,
    input  rs_div_pkg::entry_mask_t    grant,
    output rs_div_pkg::entry_idx_t     tail,
    output rs_div_pkg::entry_mask_t    busy,
    output rs_div_pkg::payload_array_t payload
);

    rs_div_pkg::entry_idx_t  tail_next;
    rs_div_pkg::entry_mask_t busy_next;

    // tail wraps without looking at busy
    always_comb begin
        if (tail == rs_div_pkg::entry_idx_t'(rs_div_pkg::rs_entries - 1)) begin
            tail_next = '0;
        end else begin
            tail_next = tail + 1'b1;
        end
    end

    always_comb begin
        busy_next = busy & ~grant; // issued entries free up
        if (dispatch_valid) begin
            busy_next[tail] = 1'b1;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tail <= '0;
            busy <= '0;
        end else begin
            busy <= busy_next;
            if (dispatch_valid) begin
                tail <= tail_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dispatch_valid) begin
            payload[tail].pc    <= pc;
            payload[tail].rd    <= rd;
            payload[tail].aluop <= aluop;
        end
    end

    // no full flag so the producer must not overrun the station
    dispatch_free_a: assert property (
        @(posedge clk) disable iff (reset)
        dispatch_valid |-> (!busy[tail] || grant[tail])
    ) else $error("dispatch into busy entry %0d", tail);

endmodule

//--- operand_slot.sv
`timescale 1ns/1ps

module operand_slot (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      dispatch_valid,
    input  rs_div_pkg::entry_idx_t    tail,
    input  rs_div_pkg::dispatch_src_t src,
    input  rs_div_pkg::result_buses_t buses,
    input  rs_div_pkg::entry_mask_t   grant,
    output rs_div_pkg::entry_mask_t   ready,
    output rs_div_pkg::data_array_t   data
);

    typedef struct packed {
        logic              hit;
        rs_div_pkg::data_t data;
    } bus_match_t;

    rs_div_pkg::tag_t        tags [rs_div_pkg::rs_entries];
    bus_match_t              wake [rs_div_pkg::rs_entries];
    bus_match_t              bypass;
    logic                    take_bus;
    rs_div_pkg::entry_mask_t ready_next;

    // first valid bus in priority order carrying the tag
    function automatic bus_match_t find_bus(
        input rs_div_pkg::tag_t          tag,
        input rs_div_pkg::result_buses_t b
    );
        bus_match_t m;
        int         idx;
        m = '0;
        for (int i = 0; i < rs_div_pkg::num_buses; i++) begin
            idx = rs_div_pkg::bus_prio[i];
            if (!m.hit && b[idx].valid && b[idx].tag == tag) begin
                m.hit  = 1'b1;
                m.data = b[idx].data;
            end
        end
        return m;
    endfunction

    always_comb begin
        bypass   = find_bus(src.tag, buses);
        take_bus = !src.valid && bypass.hit; // same-cycle capture at dispatch
    end

    always_comb begin
        for (int e = 0; e < rs_div_pkg::rs_entries; e++) begin
            wake[e] = find_bus(tags[e], buses);
        end
    end

    always_comb begin
        ready_next = ready;
        for (int e = 0; e < rs_div_pkg::rs_entries; e++) begin
            if (wake[e].hit) begin
                ready_next[e] = 1'b1;
            end
        end
        ready_next = ready_next & ~grant; // issue wins over wakeup
        if (dispatch_valid) begin
            ready_next[tail] = src.valid || bypass.hit;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ready <= '0;
        end else begin
            ready <= ready_next;
        end
    end

    always_ff @(posedge clk) begin
        for (int e = 0; e < rs_div_pkg::rs_entries; e++) begin
            if (!ready[e] && wake[e].hit) begin
                data[e] <= wake[e].data; // hold value once captured
            end
        end
        if (dispatch_valid) begin
            tags[tail] <= src.tag;
            data[tail] <= take_bus ? bypass.data : src.data;
        end
    end

endmodule

//--- issue_select.sv
`timescale 1ns/1ps

module issue_select (
    input  logic                       clk,
    input  logic                       reset,
    input  rs_div_pkg::entry_mask_t    busy,
    input  rs_div_pkg::entry_mask_t    ready1,
    input  rs_div_pkg::entry_mask_t    ready2,
    input  rs_div_pkg::data_array_t    data1,
    input  rs_div_pkg::data_array_t    data2,
    input  rs_div_pkg::payload_array_t payload,
    output rs_div_pkg::entry_mask_t    grant,
    output rs_div_pkg::issue_t         issue
);

    rs_div_pkg::entry_mask_t cand;
    rs_div_pkg::entry_idx_t  pick;

    assign cand = busy & ready1 & ready2;

    // isolate lowest set bit
    assign grant = cand & (~cand + 1'b1);

    always_comb begin
        pick = '0;
        for (int e = 0; e < rs_div_pkg::rs_entries; e++) begin
            if (grant[e]) begin
                pick = rs_div_pkg::entry_idx_t'(e);
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            issue <= '0;
        end else if (|cand) begin
            issue.valid <= 1'b1;
            issue.pc    <= payload[pick].pc;
            issue.rd    <= payload[pick].rd;
            issue.aluop <= payload[pick].aluop;
            issue.data1 <= data1[pick];
            issue.data2 <= data2[pick];
        end else begin
            issue <= '0; // idle word to divider
        end
    end

    grant_onehot_a: assert property (
        @(posedge clk) disable iff (reset)
        $onehot0(grant)
    ) else $error("grant not one-hot: %h", grant);

    issue_after_grant_a: assert property (
        @(posedge clk) disable iff (reset)
        issue.valid |-> $past(|grant)
    ) else $error("issue without grant");

endmodule

//--- rs_div.sv
`timescale 1ns/1ps

module rs_div (
    input  logic                      clk,
    input  logic                      reset,
    input  rs_div_pkg::dispatch_t     dispatch,
    input  rs_div_pkg::result_buses_t buses,
    output rs_div_pkg::issue_t        issue
);

    rs_div_pkg::entry_idx_t     tail;
    rs_div_pkg::entry_mask_t    busy;
    rs_div_pkg::entry_mask_t    grant;
    rs_div_pkg::entry_mask_t    ready1;
    rs_div_pkg::entry_mask_t    ready2;
    rs_div_pkg::data_array_t    data1;
    rs_div_pkg::data_array_t    data2;
    rs_div_pkg::payload_array_t payload;

    entry_alloc entry_alloc_i (
        .clk            (clk),
        .reset          (reset),
        .dispatch_valid (dispatch.valid),
        .pc             (dispatch.pc),
        .rd             (dispatch.rd),
        .aluop          (dispatch.aluop),
        .grant          (grant),
        .tail           (tail),
        .busy           (busy),
        .payload        (payload)
    );

    // first source operand
    operand_slot operand_slot1_i (
        .clk            (clk),
        .reset          (reset),
        .dispatch_valid (dispatch.valid),
        .tail           (tail),
        .src            (dispatch.src1),
        .buses          (buses),
        .grant          (grant),
        .ready          (ready1),
        .data           (data1)
    );

    // second source operand
    operand_slot operand_slot2_i (
        .clk            (clk),
        .reset          (reset),
        .dispatch_valid (dispatch.valid),
        .tail           (tail),
        .src            (dispatch.src2),
        .buses          (buses),
        .grant          (grant),
        .ready          (ready2),
        .data           (data2)
    );

    issue_select issue_select_i (
        .clk     (clk),
        .reset   (reset),
        .busy    (busy),
        .ready1  (ready1),
        .ready2  (ready2),
        .data1   (data1),
        .data2   (data2),
        .payload (payload),
        .grant   (grant),
        .issue   (issue)
    );

endmodule

//--- tb_rs_div.sv
`timescale 1ns/1ps

module tb_rs_div;

    localparam string test_file   = "rs_div_tests.txt";
    localparam int    drain_limit = 2 * rs_div_pkg::rs_entries + 4;

    logic                      clk = 1'b0;
    logic                      reset;
    rs_div_pkg::dispatch_t     dispatch;
    rs_div_pkg::result_buses_t buses;
    rs_div_pkg::issue_t        issue;

    rs_div_pkg::dispatch_t     next_dispatch;
    rs_div_pkg::result_buses_t next_buses;
    rs_div_pkg::issue_t        expected_q [$];

    int cycles       = 0;
    int cycle_limit  = 1000;
    int checks       = 0;
    int issue_errors = 0; // owned by the issue monitor
    int run_errors   = 0;
    int tests        = 0;

    rs_div rs_div_i (
        .clk      (clk),
        .reset    (reset),
        .dispatch (dispatch),
        .buses    (buses),
        .issue    (issue)
    );

    always #5 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            issue_errors++;
            $display("error %s: got %h, expected %h", name, actual, expected);
        end
    endtask

    // every issued word is matched against the oldest expected one
    always @(negedge clk) begin : issue_monitor
        rs_div_pkg::issue_t want;
        if (reset === 1'b0 && issue.valid === 1'b1) begin
            if (expected_q.size() == 0) begin
                issue_errors++;
                $display("unexpected issue of pc %h while nothing was expected", issue.pc);
            end else begin
                want = expected_q.pop_front();
                check_value("issue.pc", issue.pc, want.pc);
                check_value("issue.rd", 32'(issue.rd), 32'(want.rd));
                check_value("issue.aluop", 32'(issue.aluop), 32'(want.aluop));
                check_value("issue.data1", issue.data1, want.data1);
                check_value("issue.data2", issue.data2, want.data2);
            end
        end else if (reset === 1'b0) begin
            check_value("issue.pc", issue.pc, 32'h0); // idle word is all zero
            check_value("issue.rd", 32'(issue.rd), 32'h0);
            check_value("issue.aluop", 32'(issue.aluop), 32'h0);
            check_value("issue.data1", issue.data1, 32'h0);
            check_value("issue.data2", issue.data2, 32'h0);
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout: run still going after %0d cycles", cycle_limit);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // staged inputs go out on the next rising edge, then fall back to idle
    task automatic apply_cycle();
        @(posedge clk);
        dispatch      <= next_dispatch;
        buses         <= next_buses;
        next_dispatch = '0;
        next_buses    = '0;
    endtask

    // with execute low this only counts records and idle cycles
    task automatic run_file(input bit execute, output bit file_ok,
                            output int records, output int idle_cycles);
        int                 fd;
        int                 c;
        int                 n;
        int                 test_id;
        int                 waited;
        int                 errors_before;
        bit                 done;
        logic [7:0]         kind;
        logic [31:0]        f [10];
        string              rest;
        rs_div_pkg::issue_t want;
        records       = 0;
        idle_cycles   = 0;
        errors_before = 0;
        done          = 1'b0;
        fd            = $fopen(test_file, "r");
        file_ok       = (fd != 0);
        if (!file_ok) begin
            $display("cannot open test file %s", test_file);
            done = 1'b1;
        end
        while (!done) begin
            c    = $fgetc(fd);
            kind = c[7:0];
            n    = 0;
            if (c < 0) begin
                done = 1'b1;
            end else if (kind == "#") begin
                n = $fgets(rest, fd); // column notes
            end else if (kind == " " || kind == "\n" || kind == "\r" || kind == "\t") begin
                n = 0;
            end else if (kind == "D") begin
                n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h",
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
                records++;
                if (n != 9) begin
                    file_ok = 1'b0;
                end else if (execute) begin
                    next_dispatch.valid      = 1'b1;
                    next_dispatch.pc         = f[0];
                    next_dispatch.rd         = f[1][7:0];
                    next_dispatch.aluop      = f[2][3:0];
                    next_dispatch.src1.tag   = f[3][7:0];
                    next_dispatch.src1.data  = f[4];
                    next_dispatch.src1.valid = f[5][0];
                    next_dispatch.src2.tag   = f[6][7:0];
                    next_dispatch.src2.data  = f[7];
                    next_dispatch.src2.valid = f[8][0];
                    apply_cycle();
                end
            end else if (kind == "B") begin
                n = $fscanf(fd, "%h %h %h", f[0], f[1], f[2]);
                records++;
                if (n != 3) begin
                    file_ok = 1'b0;
                end else if (execute) begin
                    next_buses[f[0][1:0]].valid = 1'b1; // joins the next cycle
                    next_buses[f[0][1:0]].tag   = f[1][7:0];
                    next_buses[f[0][1:0]].data  = f[2];
                end
            end else if (kind == "I") begin
                n = $fscanf(fd, "%d", f[0]);
                records++;
                idle_cycles = idle_cycles + int'(f[0]);
                if (n != 1) begin
                    file_ok = 1'b0;
                end else if (execute) begin
                    repeat (f[0]) apply_cycle();
                end
            end else if (kind == "E") begin
                n = $fscanf(fd, "%h %h %h %h %h", f[0], f[1], f[2], f[3], f[4]);
                records++;
                if (n != 5) begin
                    file_ok = 1'b0;
                end else if (execute) begin
                    want       = '0;
                    want.valid = 1'b1;
                    want.pc    = f[0];
                    want.rd    = f[1][7:0];
                    want.aluop = f[2][3:0];
                    want.data1 = f[3];
                    want.data2 = f[4];
                    expected_q.push_back(want);
                end
            end else if (kind == "T") begin
                n = $fscanf(fd, "%d", f[0]);
                records++;
                if (n != 1) begin
                    file_ok = 1'b0;
                end else if (execute) begin
                    test_id = int'(f[0]);
                    apply_cycle();
                    waited = 0;
                    while (expected_q.size() != 0 && waited < drain_limit) begin
                        apply_cycle();
                        waited++;
                    end
                    repeat (2) apply_cycle(); // lets a stray issue show up
                    if (expected_q.size() != 0) begin
                        run_errors++;
                        $display("test %0d: %0d expected issues never came out",
                                 test_id, expected_q.size());
                        expected_q.delete();
                    end
                    $display("test %0d done, %0d errors",
                             test_id, run_errors + issue_errors - errors_before);
                    errors_before = run_errors + issue_errors;
                    tests++;
                end
            end else begin
                file_ok = 1'b0;
            end
            if (!file_ok && !done) begin
                $display("malformed record %0d in test file", records);
                done = 1'b1;
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
    endtask

    initial begin
        bit file_ok;
        int records;
        int idle_cycles;
        reset         <= 1'b1;
        dispatch      <= '0;
        buses         <= '0;
        next_dispatch = '0;
        next_buses    = '0;
        run_file(1'b0, file_ok, records, idle_cycles);
        cycle_limit = 10 * (records + idle_cycles + 2);
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        if (file_ok) begin
            run_file(1'b1, file_ok, records, idle_cycles);
        end else begin
            run_errors++;
        end
        $display("%0d tests, %0d checks, %0d errors", tests, checks, run_errors + issue_errors);
        if (run_errors + issue_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- rs_div_tests.txt
# D pc rd aluop tag1 data1 valid1 tag2 data2 valid2 / B bus tag data / I idle_cycles (decimal)
# E pc rd aluop data1 data2 / T test_number; B lines share the cycle of the next D or I line
# test 1: reset, idle, no issue
I 4
T 1
# test 2: both sources ready at dispatch
D 00001000 21 3 00 00000064 1 00 00000007 1
E 00001000 21 3 00000064 00000007
T 2
# test 3: wakeup on MUL, DIV, MEM and ALU, non-matching tag first
D 00001100 22 4 10 00000000 0 00 00000003 1
D 00001104 23 5 11 00000000 0 12 00000000 0
B 0 77 deadbeef
I 4
E 00001100 22 4 0000aaaa 00000003
B 1 10 0000aaaa
I 3
E 00001104 23 5 11111111 22222222
B 2 11 11111111
I 2
B 3 12 22222222
I 3
D 00001108 24 6 00 00000005 1 13 00000000 0
I 2
E 00001108 24 6 00000005 33333333
B 0 13 33333333
I 3
T 3
# test 4: same-cycle bypass, ALU beats MEM, idle bus never bypasses
B 1 20 44444444
D 00001200 25 7 20 00000000 0 00 00000009 1
E 00001200 25 7 44444444 00000009
B 0 21 55555555
B 3 21 66666666
D 00001204 26 8 21 00000000 0 21 00000000 0
E 00001204 26 8 55555555 55555555
B 2 22 77777777
B 3 23 88888888
D 00001208 27 9 22 00000000 0 23 00000000 0
E 00001208 27 9 77777777 88888888
D 0000120c 28 a 00 00000000 0 00 0000000b 1
I 4
E 0000120c 28 a 99999999 0000000b
B 0 00 99999999
I 3
T 4
# test 5: sixteen entries from tail 8 wrap round, one broadcast, issue by entry index
D 00002020 48 8 30 00000000 0 00 00000108 1
D 00002024 49 9 30 00000000 0 00 00000109 1
D 00002028 4a a 30 00000000 0 00 0000010a 1
D 0000202c 4b b 30 00000000 0 00 0000010b 1
D 00002030 4c c 30 00000000 0 00 0000010c 1
D 00002034 4d d 30 00000000 0 00 0000010d 1
D 00002038 4e e 30 00000000 0 00 0000010e 1
D 0000203c 4f f 30 00000000 0 00 0000010f 1
D 00002000 40 0 30 00000000 0 00 00000100 1
D 00002004 41 1 30 00000000 0 00 00000101 1
D 00002008 42 2 30 00000000 0 00 00000102 1
D 0000200c 43 3 30 00000000 0 00 00000103 1
D 00002010 44 4 30 00000000 0 00 00000104 1
D 00002014 45 5 30 00000000 0 00 00000105 1
D 00002018 46 6 30 00000000 0 00 00000106 1
D 0000201c 47 7 30 00000000 0 00 00000107 1
E 00002000 40 0 cafe0030 00000100
E 00002004 41 1 cafe0030 00000101
E 00002008 42 2 cafe0030 00000102
E 0000200c 43 3 cafe0030 00000103
E 00002010 44 4 cafe0030 00000104
E 00002014 45 5 cafe0030 00000105
E 00002018 46 6 cafe0030 00000106
E 0000201c 47 7 cafe0030 00000107
E 00002020 48 8 cafe0030 00000108
E 00002024 49 9 cafe0030 00000109
E 00002028 4a a cafe0030 0000010a
E 0000202c 4b b cafe0030 0000010b
E 00002030 4c c cafe0030 0000010c
E 00002034 4d d cafe0030 0000010d
E 00002038 4e e cafe0030 0000010e
E 0000203c 4f f cafe0030 0000010f
I 2
B 2 30 cafe0030
I 1
T 5
# test 6: drained entries reused after the wrap
D 00003000 50 1 00 00000011 1 00 00000022 1
E 00003000 50 1 00000011 00000022
D 00003004 51 2 00 00000033 1 00 00000044 1
E 00003004 51 2 00000033 00000044
T 6

//--- flist.f
rs_div_pkg.sv
entry_alloc.sv
operand_slot.sv
issue_select.sv
rs_div.sv
tb_rs_div.sv

//--- run.sh
#!/bin/sh
# compile and run the reservation station testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module tb_rs_div -f flist.f -o sim_rs_div \
    && ./obj_dir/sim_rs_div > sim.log 2>&1 \
    || echo "ERRORS FOUND in build or simulation" >> sim.log

cat sim.log

# the testbench prints the fail message on any failed check or timeout
grep -q "ERRORS FOUND" sim.log && { echo "simulation failed"; exit 1; }
echo "simulation passed"
exit 0
